// File: mem_input.txt
// op a b c d, all fields hex, unused fields 0
// dw and dr take lo addr, hi addr, lo word, hi word (expected words for dr)
// iw takes word addr, size, lo word, hi word; ir takes word addr, 0, expected lo and hi
// DCCM aligned pairs
dw 040 044 15deadbeef 2acafef00d
dw 048 04c 0311223344 7f55667788
dr 040 044 15deadbeef 2acafef00d
dr 048 04c 0311223344 7f55667788
dr 044 040 2acafef00d 15deadbeef
dr 04c 048 7f55667788 0311223344
dr 044 048 2acafef00d 0311223344
dw 040 044 6600000001 1100000002
dr 040 044 6600000001 1100000002
dw 3f8 3fc 0fedcba987 70f0f0f0f0
dr 3fc 3f8 70f0f0f0f0 0fedcba987
// DCCM neighbours of the unaligned pair
dw 0b0 0b4 2100000b00 2200000b04
dw 0b8 0c4 2300000b08 2400000c04
dw 0c8 0cc 2500000c08 2600000c0c
// DCCM unaligned, lo in bank 3 of row b, hi in bank 0 of row c
dw 0be 0c1 4a5a6a7a8a 0b1b2b3b4b
dr 0be 0c1 4a5a6a7a8a 0b1b2b3b4b
dr 0bc 0c0 4a5a6a7a8a 0b1b2b3b4b
dr 0c0 0bc 0b1b2b3b4b 4a5a6a7a8a
dr 0b0 0b4 2100000b00 2200000b04
dr 0b8 0c4 2300000b08 2400000c04
dr 0c8 0cc 2500000c08 2600000c0c
// DCCM lo and hi in the same bank, hi word is dropped
dw 200 204 3300000200 3400000204
dw 100 104 3500000100 3600000104
dr 100 104 3500000100 3600000104
dw 100 200 7700000aaa 7800000bbb
dr 100 104 7700000aaa 3600000104
dr 200 204 3300000200 3400000204
dw 108 108 1a2b3c4d5e 6f00000000
dr 108 108 1a2b3c4d5e 1a2b3c4d5e
// ICCM double writes in row 4
iw 010 3 5a11112222 2b33334444
iw 012 3 1c55556666 0d77778888
ir 010 0 5a11112222 2b33334444
ir 012 0 1c55556666 0d77778888
// ICCM single writes, the hi word must not land anywhere
iw 011 2 7e9999aaaa 3fbbbbcccc
ir 010 0 5a11112222 7e9999aaaa
ir 011 0 7e9999aaaa 1c55556666
ir 012 0 1c55556666 0d77778888
iw 013 0 4fdddd0000 60eeee1111
ir 012 0 1c55556666 4fdddd0000
ir 010 0 5a11112222 7e9999aaaa
// ICCM double write from bank 3 of row 8 into bank 0 of row 9
iw 020 3 1100000020 1200000021
iw 022 2 1300000022 0
iw 024 3 1400000024 1500000025
ir 024 0 1400000024 1500000025
iw 023 3 6a0a0b0c0d 3b1e2f3041
ir 023 0 6a0a0b0c0d 3b1e2f3041
ir 020 0 1100000020 1200000021
ir 022 0 1300000022 6a0a0b0c0d
ir 024 0 3b1e2f3041 1500000025
// DCCM contents survive the ICCM traffic
dr 0be 0c1 4a5a6a7a8a 0b1b2b3b4b
dr 040 044 6600000001 1100000002
dr 3f8 3fc 0fedcba987 70f0f0f0f0

// File: sim.f
mem_cfg_pkg.sv
mem_types_pkg.sv
sram_bank_array.sv
dccm_mem.sv
iccm_mem.sv
core_mem.sv
mem_subsys_top.sv
mem_subsys_chk.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsys -f sim.f -o tb_sim \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAIL, no verdict in the log"; exit 1; }
echo "PASS"

// File: tb_mem_subsys.sv
`timescale 1ns/100ps
/* Testbench for the memory subsystem. Runs the records of mem_input.txt in order
   and checks every read one clock after its strobe. A read of an SRAM row that
   was never written returns X and fails its compare. */
module tb_mem_subsys;

   localparam int fw        = mem_cfg_pkg::fdata_width;
   localparam int dw        = mem_cfg_pkg::data_width;
   localparam int max_lines = 200;   // Bound on data file lines
   localparam int reset_max = 32;    // Cycles allowed for the outputs to settle

   // Data file record with a two character op
   typedef struct packed {
      logic [15:0] op;
      logic [79:0] a;
      logic [79:0] b;
      logic [79:0] c;
      logic [79:0] d;
   } op_rec_t;

   logic clk;
   logic rst_n;
   logic dccm_wren;
   logic dccm_rden;
   logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_lo;
   logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_hi;
   logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_lo;
   logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_hi;
   logic [fw-1:0] dccm_wr_data_lo;
   logic [fw-1:0] dccm_wr_data_hi;
   logic [fw-1:0] dccm_rd_data_lo;
   logic [fw-1:0] dccm_rd_data_hi;
   logic iccm_wren;
   logic iccm_rden;
   logic [mem_cfg_pkg::iccm_word_bits-1:0] iccm_rw_addr;
   logic [2:0] iccm_wr_size;
   logic [2*fw-1:0] iccm_wr_data;
   logic [2*dw-1:0] iccm_rd_data;
   logic [2*fw-1:0] iccm_rd_data_ecc;

   mem_subsys_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   task automatic abort_run();
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [79:0] got,
                              input logic [79:0] exp);
      assert (got === exp) else begin
         $display("error %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // Bound bus checkers latch their failures
   task automatic check_bus_checkers();
      assert (!uut.core.dccm.dccm_chk.fired && !uut.core.iccm.iccm_chk.fired) else begin
         $display("a bank request bus assertion failed");
         abort_run();
      end
   endtask

   // ******************************
   // Each operation starts and ends on a falling edge
   // ******************************
   task automatic dccm_write(input op_rec_t rec);
      dccm_wr_addr_lo = rec.a[mem_cfg_pkg::dccm_bits-1:0];
      dccm_wr_addr_hi = rec.b[mem_cfg_pkg::dccm_bits-1:0];
      dccm_wr_data_lo = rec.c[fw-1:0];
      dccm_wr_data_hi = rec.d[fw-1:0];
      dccm_wren = 1'b1;
      @(negedge clk);
      dccm_wren = 1'b0;
   endtask

   task automatic dccm_read(input op_rec_t rec);
      dccm_rd_addr_lo = rec.a[mem_cfg_pkg::dccm_bits-1:0];
      dccm_rd_addr_hi = rec.b[mem_cfg_pkg::dccm_bits-1:0];
      dccm_rden = 1'b1;
      @(negedge clk);
      dccm_rden = 1'b0;   // Data registered at the rising edge just passed
      check_value("dccm_rd_data_lo", 80'(dccm_rd_data_lo), 80'(rec.c[fw-1:0]));
      check_value("dccm_rd_data_hi", 80'(dccm_rd_data_hi), 80'(rec.d[fw-1:0]));
   endtask

   task automatic iccm_write(input op_rec_t rec);
      iccm_rw_addr = rec.a[mem_cfg_pkg::iccm_word_bits-1:0];
      iccm_wr_size = rec.b[2:0];
      iccm_wr_data = {rec.d[fw-1:0], rec.c[fw-1:0]};   // Hi word above lo word
      iccm_wren = 1'b1;
      @(negedge clk);
      iccm_wren = 1'b0;
   endtask

   task automatic iccm_read(input op_rec_t rec);
      logic [2*fw-1:0] exp_ecc;
      logic [2*dw-1:0] exp_data;
      exp_ecc  = {rec.d[fw-1:0], rec.c[fw-1:0]};
      exp_data = {rec.d[dw-1:0], rec.c[dw-1:0]};   // Check bits dropped
      iccm_rw_addr = rec.a[mem_cfg_pkg::iccm_word_bits-1:0];
      iccm_rden = 1'b1;
      @(negedge clk);
      iccm_rden = 1'b0;
      check_value("iccm_rd_data", 80'(iccm_rd_data), 80'(exp_data));
      check_value("iccm_rd_data_ecc", 80'(iccm_rd_data_ecc), 80'(exp_ecc));
   endtask

   // ******************************
   // Data file reader
   // ******************************
   task automatic run_file();
      int fd;
      int r;
      int lines;
      int ops;
      bit done;
      op_rec_t rec;
      logic [15:0] op;
      logic [79:0] field_a;
      logic [79:0] field_b;
      logic [79:0] field_c;
      logic [79:0] field_d;
      logic [8*160-1:0] rest;
      fd = $fopen("mem_input.txt", "r");
      if (fd == 0) begin
         $display("could not open the data file mem_input.txt");
         abort_run();
      end else begin
         done  = 1'b0;
         lines = 0;
         ops   = 0;
         while (!done && lines < max_lines) begin
            lines++;
            r = $fscanf(fd, "%s", op);
            if (r != 1) begin
               done = 1'b1;   // End of file
            end else if (op == "//") begin
               r = $fgets(rest, fd);
            end else begin
               r = $fscanf(fd, "%h %h %h %h", field_a, field_b, field_c, field_d);
               if (r != 4) begin
                  $display("data file record %0d has missing fields", ops + 1);
                  abort_run();
               end else begin
                  ops++;
                  rec = {op, field_a, field_b, field_c, field_d};
                  case (rec.op)
                     "dw": dccm_write(rec);
                     "dr": dccm_read(rec);
                     "iw": iccm_write(rec);
                     "ir": iccm_read(rec);
                     default: begin
                        $display("data file record %0d has an unknown operation", ops);
                        abort_run();
                     end
                  endcase
                  check_bus_checkers();
               end
            end
         end
         if (!done) begin
            $display("data file not finished after %0d lines", max_lines);
            abort_run();
         end else if (ops == 0) begin
            $display("data file holds no operations");
            abort_run();
         end else begin
            $fclose(fd);
         end
      end
   endtask

   task automatic wait_reset_done();
      int cycles;
      bit ready;
      cycles = 0;
      ready  = 1'b0;
      while (!ready && cycles < reset_max) begin
         @(negedge clk);
         cycles++;
         ready = rst_n && (dccm_rd_data_lo === '0) && (iccm_rd_data_ecc === '0);
      end
      if (!ready) begin
         $display("read data did not settle to zero after reset");
         abort_run();
      end
   endtask

   initial begin
      rst_n = 1'b0;
      dccm_wren = 1'b0;
      dccm_rden = 1'b0;
      dccm_wr_addr_lo = '0;
      dccm_wr_addr_hi = '0;
      dccm_rd_addr_lo = '0;
      dccm_rd_addr_hi = '0;
      dccm_wr_data_lo = '0;
      dccm_wr_data_hi = '0;
      iccm_wren = 1'b0;
      iccm_rden = 1'b0;
      iccm_rw_addr = '0;
      iccm_wr_size = '0;
      iccm_wr_data = '0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      wait_reset_done();
      check_bus_checkers();
      run_file();
      $display("sim passed");
      $finish;
   end

endmodule

// File: mem_subsys_chk.sv
`timescale 1ns/100ps
/* Checks on a bank request bus, bound into both memory controllers.
   wr_double is tied low for the DCCM, which has no double write. */
module mem_subsys_chk #(
   parameter int banks = 4
) (
   input logic clk,
   input logic rst_n,
   input logic [banks-1:0] clken,
   input logic [banks-1:0] wren,
   input logic wr_double
);

   logic [banks-1:0] wren_rot;
   logic             fired = 1'b0;   // Latches any failure below

   assign wren_rot = {wren[banks-2:0], wren[banks-1]};   // Top bank wraps to bank 0

   // Lo and hi can claim two banks at most
   wr_count: assert property (@(posedge clk) disable iff (!rst_n)
      $countones(wren) <= 2)
      else begin
         fired = 1'b1;
         $error("more than two bank write enables set %b", wren);
      end

   double_adjacent: assert property (@(posedge clk) disable iff (!rst_n)
      wr_double |-> ($countones(wren) == 2) && ((wren & wren_rot) != '0))
      else begin
         fired = 1'b1;
         $error("double write did not enable two adjacent banks %b", wren);
      end

   reset_idle: assert property (@(posedge clk) !rst_n |-> clken == '0)
      else begin
         fired = 1'b1;
         $error("bank clock enable set during reset %b", clken);
      end

endmodule

bind dccm_mem mem_subsys_chk #(.banks(mem_cfg_pkg::dccm_banks)) dccm_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .clken    (bank_req.clken),
   .wren     (bank_req.wren),
   .wr_double(1'b0)
);

bind iccm_mem mem_subsys_chk #(.banks(mem_cfg_pkg::iccm_banks)) iccm_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .clken    (bank_req.clken),
   .wren     (bank_req.wren),
   .wr_double(iccm_wren && (iccm_wr_size == 3'd3))
);

// File: mem_subsys_top.sv
`timescale 1ns/100ps
/* Memory subsystem with the SRAM models attached to the core memory block.
   Same strobe rules as core_mem, no back-pressure. */
module mem_subsys_top (
   input  logic clk,
   input  logic rst_n,

   input  logic dccm_wren,
   input  logic dccm_rden,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_hi,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_hi,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_lo,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_hi,
   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_lo,
   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_hi,

   input  logic iccm_wren,
   input  logic iccm_rden,
   input  logic [mem_cfg_pkg::iccm_word_bits-1:0] iccm_rw_addr,
   input  logic [2:0] iccm_wr_size,
   input  logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_wr_data,
   output logic [2*mem_cfg_pkg::data_width-1:0] iccm_rd_data,
   output logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_rd_data_ecc
);

   mem_types_pkg::dccm_bank_req_t dccm_req;
   mem_types_pkg::dccm_bank_rsp_t dccm_rsp;
   mem_types_pkg::iccm_bank_req_t iccm_req;
   mem_types_pkg::iccm_bank_rsp_t iccm_rsp;

   core_mem core (
      .*,
      .dccm_export_req(dccm_req),
      .dccm_export_rsp(dccm_rsp),
      .iccm_export_req(iccm_req),
      .iccm_export_rsp(iccm_rsp)
   );

   sram_bank_array #(
      .row_bits(mem_cfg_pkg::dccm_row_bits),
      .req_t   (mem_types_pkg::dccm_bank_req_t),
      .rsp_t   (mem_types_pkg::dccm_bank_rsp_t)
   ) dccm_sram (.clk(clk), .rst_n(rst_n), .req(dccm_req), .rsp(dccm_rsp));

   sram_bank_array #(
      .row_bits(mem_cfg_pkg::iccm_row_bits),
      .req_t   (mem_types_pkg::iccm_bank_req_t),
      .rsp_t   (mem_types_pkg::iccm_bank_rsp_t)
   ) iccm_sram (.clk(clk), .rst_n(rst_n), .req(iccm_req), .rsp(iccm_rsp));

endmodule

// File: core_mem.sv
`timescale 1ns/100ps
/* Memory block wrapper. Holds the DCCM and ICCM controllers and exports their
   bank buses, the SRAMs themselves live outside. Both memories always exist. */
module core_mem (
   input  logic clk,
   input  logic rst_n,

   // DCCM ports
   input  logic dccm_wren,
   input  logic dccm_rden,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_hi,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_hi,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_lo,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_hi,
   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_lo,
   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_hi,

   // ICCM ports
   input  logic iccm_wren,
   input  logic iccm_rden,
   input  logic [mem_cfg_pkg::iccm_word_bits-1:0] iccm_rw_addr,
   input  logic [2:0] iccm_wr_size,
   input  logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_wr_data,
   output logic [2*mem_cfg_pkg::data_width-1:0] iccm_rd_data,
   output logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_rd_data_ecc,

   // Exported SRAM buses
   output mem_types_pkg::dccm_bank_req_t dccm_export_req,
   input  mem_types_pkg::dccm_bank_rsp_t dccm_export_rsp,
   output mem_types_pkg::iccm_bank_req_t iccm_export_req,
   input  mem_types_pkg::iccm_bank_rsp_t iccm_export_rsp
);

   // ******************************
   // DCCM
   // ******************************
   dccm_mem dccm (
      .*,
      .bank_req(dccm_export_req),
      .bank_rsp(dccm_export_rsp)
   );

   // ******************************
   // ICCM
   // ******************************
   iccm_mem iccm (
      .*,
      .bank_req(iccm_export_req),
      .bank_rsp(iccm_export_rsp)
   );

endmodule

// File: iccm_mem.sv
`timescale 1ns/100ps
/* ICCM controller. The address is a word address, halfword offsets not supported.
   Size 3 writes two consecutive words, any other size writes one. Reads always
   return two words. Never strobe read and write together. */
module iccm_mem (
   input  logic clk,
   input  logic rst_n,

   input  logic iccm_wren,
   input  logic iccm_rden,
   input  logic [mem_cfg_pkg::iccm_word_bits-1:0] iccm_rw_addr,
   input  logic [2:0] iccm_wr_size,
   input  logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_wr_data,

   output logic [2*mem_cfg_pkg::data_width-1:0] iccm_rd_data,
   output logic [2*mem_cfg_pkg::fdata_width-1:0] iccm_rd_data_ecc,

   output mem_types_pkg::iccm_bank_req_t bank_req,
   input  mem_types_pkg::iccm_bank_rsp_t bank_rsp
);

   logic [mem_cfg_pkg::iccm_word_bits-1:0] addr_hi;
   logic [mem_cfg_pkg::iccm_bank_bits-1:0] bank_lo;
   logic [mem_cfg_pkg::iccm_bank_bits-1:0] bank_hi;
   logic [mem_cfg_pkg::iccm_row_bits-1:0]  row_lo;
   logic [mem_cfg_pkg::iccm_row_bits-1:0]  row_hi;
   logic [mem_cfg_pkg::iccm_banks-1:0]     sel_lo;
   logic [mem_cfg_pkg::iccm_banks-1:0]     sel_hi;
   logic [mem_cfg_pkg::iccm_banks-1:0]     wr_sel;
   logic [mem_cfg_pkg::iccm_banks-1:0]     rd_sel;
   logic                                   wr_double;
   logic [mem_cfg_pkg::iccm_bank_bits-1:0] rd_bank_q;
   logic [mem_cfg_pkg::iccm_bank_bits-1:0] rd_bank_nxt;
   logic [mem_cfg_pkg::fdata_width-1:0]    word_lo;
   logic [mem_cfg_pkg::fdata_width-1:0]    word_hi;

   // ******************************
   // Address decode
   // ******************************
   // Carry out of the bank field bumps the row
   assign addr_hi = iccm_rw_addr + 1'b1;

   assign bank_lo = iccm_rw_addr[mem_cfg_pkg::iccm_bank_bits-1:0];
   assign bank_hi = addr_hi[mem_cfg_pkg::iccm_bank_bits-1:0];
   assign row_lo  = iccm_rw_addr[mem_cfg_pkg::iccm_word_bits-1 -: mem_cfg_pkg::iccm_row_bits];
   assign row_hi  = addr_hi[mem_cfg_pkg::iccm_word_bits-1 -: mem_cfg_pkg::iccm_row_bits];

   assign sel_lo = {{(mem_cfg_pkg::iccm_banks-1){1'b0}}, 1'b1} << bank_lo;
   assign sel_hi = {{(mem_cfg_pkg::iccm_banks-1){1'b0}}, 1'b1} << bank_hi;

   assign wr_double = (iccm_wr_size == 3'd3);

   assign wr_sel = {mem_cfg_pkg::iccm_banks{iccm_wren}} &
                   (sel_lo | (sel_hi & {mem_cfg_pkg::iccm_banks{wr_double}}));
   assign rd_sel = {mem_cfg_pkg::iccm_banks{iccm_rden}} & (sel_lo | sel_hi);

   // ******************************
   // Bank request steering
   // ******************************
   assign bank_req.clken = wr_sel | rd_sel;
   assign bank_req.wren  = wr_sel;

   // Lo and hi never share a bank, low 39 bits go to the addressed word
   always_comb begin
      for (int b = 0; b < mem_cfg_pkg::iccm_banks; b++) begin
         bank_req.addr[b]    = sel_lo[b] ? row_lo : row_hi;
         bank_req.wr_data[b] = sel_lo[b] ?
                               iccm_wr_data[mem_cfg_pkg::fdata_width-1:0] :
                               iccm_wr_data[2*mem_cfg_pkg::fdata_width-1 -: mem_cfg_pkg::fdata_width];
      end
   end

   // ******************************
   // Read assembly
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_bank_q <= '0;
      end else if (iccm_rden) begin
         rd_bank_q <= bank_lo;
      end
   end

   assign rd_bank_nxt = rd_bank_q + 1'b1;   // Wraps 3 to 0

   assign word_lo = bank_rsp.dout[rd_bank_q];
   assign word_hi = bank_rsp.dout[rd_bank_nxt];

   assign iccm_rd_data_ecc = {word_hi, word_lo};
   assign iccm_rd_data     = {word_hi[mem_cfg_pkg::data_width-1:0],
                              word_lo[mem_cfg_pkg::data_width-1:0]};   // Data fields only

endmodule

// File: dccm_mem.sv
`timescale 1ns/100ps
/* DCCM controller. Lo and hi are byte addresses of 32-bit words, so an unaligned
   access spans two adjacent banks. Never strobe read and write together, the
   write wins and read data is then undefined. ECC is stored, not checked. */
module dccm_mem (
   input  logic clk,
   input  logic rst_n,

   input  logic dccm_wren,
   input  logic dccm_rden,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_wr_addr_hi,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_lo,
   input  logic [mem_cfg_pkg::dccm_bits-1:0] dccm_rd_addr_hi,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_lo,
   input  logic [mem_cfg_pkg::fdata_width-1:0] dccm_wr_data_hi,

   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_lo,
   output logic [mem_cfg_pkg::fdata_width-1:0] dccm_rd_data_hi,

   output mem_types_pkg::dccm_bank_req_t bank_req,
   input  mem_types_pkg::dccm_bank_rsp_t bank_rsp
);

   logic [mem_cfg_pkg::dccm_bits-1:0]      addr_lo;
   logic [mem_cfg_pkg::dccm_bits-1:0]      addr_hi;
   logic [mem_cfg_pkg::dccm_bank_bits-1:0] bank_lo;
   logic [mem_cfg_pkg::dccm_bank_bits-1:0] bank_hi;
   logic [mem_cfg_pkg::dccm_row_bits-1:0]  row_lo;
   logic [mem_cfg_pkg::dccm_row_bits-1:0]  row_hi;
   logic [mem_cfg_pkg::dccm_banks-1:0]     sel_lo;
   logic [mem_cfg_pkg::dccm_banks-1:0]     sel_hi;
   logic [mem_cfg_pkg::dccm_banks-1:0]     sel_any;
   logic [mem_cfg_pkg::dccm_bank_bits-1:0] rd_bank_lo_q;
   logic [mem_cfg_pkg::dccm_bank_bits-1:0] rd_bank_hi_q;

   // ******************************
   // Address decode
   // ******************************
   assign addr_lo = dccm_wren ? dccm_wr_addr_lo : dccm_rd_addr_lo;   // Write has priority
   assign addr_hi = dccm_wren ? dccm_wr_addr_hi : dccm_rd_addr_hi;

   assign bank_lo = addr_lo[mem_cfg_pkg::dccm_byte_bits +: mem_cfg_pkg::dccm_bank_bits];
   assign bank_hi = addr_hi[mem_cfg_pkg::dccm_byte_bits +: mem_cfg_pkg::dccm_bank_bits];
   assign row_lo  = addr_lo[mem_cfg_pkg::dccm_bits-1 -: mem_cfg_pkg::dccm_row_bits];
   assign row_hi  = addr_hi[mem_cfg_pkg::dccm_bits-1 -: mem_cfg_pkg::dccm_row_bits];

   assign sel_lo  = {{(mem_cfg_pkg::dccm_banks-1){1'b0}}, 1'b1} << bank_lo;
   assign sel_hi  = {{(mem_cfg_pkg::dccm_banks-1){1'b0}}, 1'b1} << bank_hi;
   assign sel_any = sel_lo | sel_hi;

   // ******************************
   // Bank request steering
   // ******************************
   assign bank_req.clken = {mem_cfg_pkg::dccm_banks{dccm_wren | dccm_rden}} & sel_any;
   assign bank_req.wren  = {mem_cfg_pkg::dccm_banks{dccm_wren}} & sel_any;

   // Lo side claims a bank shared with hi, so hi word is dropped then
   always_comb begin
      for (int b = 0; b < mem_cfg_pkg::dccm_banks; b++) begin
         bank_req.addr[b]    = sel_lo[b] ? row_lo : row_hi;
         bank_req.wr_data[b] = sel_lo[b] ? dccm_wr_data_lo : dccm_wr_data_hi;
      end
   end

   // ******************************
   // Read data return
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_bank_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else if (dccm_rden) begin
         rd_bank_lo_q <= bank_lo;
         rd_bank_hi_q <= bank_hi;
      end
   end

   // SRAM outputs hold, so the steered words hold until next read
   assign dccm_rd_data_lo = bank_rsp.dout[rd_bank_lo_q];
   assign dccm_rd_data_hi = bank_rsp.dout[rd_bank_hi_q];

endmodule

// File: sram_bank_array.sv
`timescale 1ns/100ps
/* Behavioral model of a banked SRAM. Writes land at the clock edge, reads are
   registered and hold until that bank's next read. Contents power up unknown.
   req_t and rsp_t must carry clken, wren, addr, wr_data and dout fields. */
module sram_bank_array #(
   parameter int  row_bits = 6,
   parameter type req_t    = mem_types_pkg::dccm_bank_req_t,
   parameter type rsp_t    = mem_types_pkg::dccm_bank_rsp_t
) (
   input  logic clk,
   input  logic rst_n,
   input  req_t req,
   output rsp_t rsp
);

   localparam int banks = $bits(rsp_t) / mem_cfg_pkg::fdata_width;

   logic [mem_cfg_pkg::fdata_width-1:0] store [banks][2**row_bits];
   logic [banks-1:0][mem_cfg_pkg::fdata_width-1:0] dout_q;

   // Write port, one per bank
   always_ff @(posedge clk) begin
      for (int b = 0; b < banks; b++) begin
         if (req.clken[b] && req.wren[b]) begin
            store[b][req.addr[b]] <= req.wr_data[b];
         end
      end
   end

   // Output latch loads only on a read, so a write leaves it alone
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dout_q <= '0;
      end else begin
         for (int b = 0; b < banks; b++) begin
            if (req.clken[b] && !req.wren[b]) begin
               dout_q[b] <= store[b][req.addr[b]];
            end
         end
      end
   end

   assign rsp.dout = dout_q;

endmodule

// File: mem_types_pkg.sv
/* Bank buses between the memory controllers and the external SRAMs.
   Request and response structs of both memories share field names,
   so one SRAM model serves either memory. */
package mem_types_pkg;

   // ******************************
   // DCCM bank buses
   // ******************************
   typedef struct packed {
      logic [mem_cfg_pkg::dccm_banks-1:0] clken;
      logic [mem_cfg_pkg::dccm_banks-1:0] wren;
      logic [mem_cfg_pkg::dccm_banks-1:0][mem_cfg_pkg::dccm_row_bits-1:0] addr;
      logic [mem_cfg_pkg::dccm_banks-1:0][mem_cfg_pkg::fdata_width-1:0] wr_data;
   } dccm_bank_req_t;   // 188 bits

   typedef struct packed {
      logic [mem_cfg_pkg::dccm_banks-1:0][mem_cfg_pkg::fdata_width-1:0] dout;
   } dccm_bank_rsp_t;   // 156 bits

   // ******************************
   // ICCM bank buses
   // ******************************
   typedef struct packed {
      logic [mem_cfg_pkg::iccm_banks-1:0] clken;
      logic [mem_cfg_pkg::iccm_banks-1:0] wren;
      logic [mem_cfg_pkg::iccm_banks-1:0][mem_cfg_pkg::iccm_row_bits-1:0] addr;
      logic [mem_cfg_pkg::iccm_banks-1:0][mem_cfg_pkg::fdata_width-1:0] wr_data;
   } iccm_bank_req_t;   // 192 bits

   typedef struct packed {
      logic [mem_cfg_pkg::iccm_banks-1:0][mem_cfg_pkg::fdata_width-1:0] dout;
   } iccm_bank_rsp_t;   // 156 bits

endpackage

// File: mem_cfg_pkg.sv
/* Sizes of the DCCM and ICCM. Bank counts must be powers of two,
   and the row widths must equal the address bits left above the bank index. */
package mem_cfg_pkg;

   // ******************************
   // DCCM, byte addressed
   // ******************************
   localparam int dccm_bits      = 10;   // Byte address width
   localparam int dccm_banks     = 4;
   localparam int dccm_row_bits  = 6;
   localparam int dccm_bank_bits = $clog2(dccm_banks);
   localparam int dccm_byte_bits = 2;    // Byte offset inside a 32-bit word

   // ******************************
   // ICCM, word addressed
   // ******************************
   localparam int iccm_word_bits = 9;    // 512 words
   localparam int iccm_banks     = 4;
   localparam int iccm_row_bits  = 7;
   localparam int iccm_bank_bits = $clog2(iccm_banks);

   // Stored word is data in the low bits, check bits above
   localparam int fdata_width = 39;
   localparam int data_width  = 32;

endpackage
